// ==== files.f ====
common/rv_core_pkg.sv
common/imem_bus_pkg.sv
fetch/redirect_ctrl.sv
fetch/fetch.sv
logic/imem_arbiter.sv
logic/imem.sv
logic/prog_loader.sv
logic/fetch_top.sv
sim/tb_clock.sv
sim/fetch_chk.sv
sim/fetch_tb.sv

// ==== sim/fetch_tb.sv ====
//############################
// Fetch front end testbench
// Loads a program, runs fetch with jumps,
// traps and back-pressure, checks every item
//############################

`timescale 1ns/1ps

module fetch_tb;

    import rv_core_pkg::*;
    import imem_bus_pkg::*;

    localparam int CLK_NS     = 4;
    localparam int TEST_CYCLES = (IMEM_WORDS + 16) * 12 + 200 * 12;   // Loads plus all items
    localparam int BUDGET_NS  = TEST_CYCLES * 20 * CLK_NS;

    logic clk, reset, run, ready;
    logic exception, interrupt_ack, mret, jump;
    addr_t jump_target, mtvec, mepc;
    logic load_req, load_ack;
    word_idx_t load_addr;
    instr_t load_data;
    fetch_out_t fetch_o;

    instr_t ref_mem [IMEM_WORDS];             // Mirror of every completed load
    addr_t  exp_pc;                           // Next expected item address
    tag_t   exp_tag;
    int     n_items, n_checks, n_errors, errs_at_start, chk_fails;

    tb_clock u_clock (.clk_o(clk));

    fetch_top dut (
        .clk (clk), .reset (reset), .run_i (run), .ready_i (ready),
        .exception_i (exception), .interrupt_ack_i (interrupt_ack),
        .mret_i (mret), .jump_i (jump), .jump_target_i (jump_target),
        .mtvec_i (mtvec), .mepc_i (mepc),
        .load_req_i (load_req), .load_addr_i (load_addr), .load_data_i (load_data),
        .load_ack_o (load_ack), .fetch_o (fetch_o)
    );

    // Reference lookup of the word at a byte address
    function automatic instr_t expected_instr(addr_t pc);
        return ref_mem[word_idx_t'(pc >> 2)];
    endfunction

    // Items with valid and ready at mid-cycle are taken at the next edge
    always @(negedge clk) begin
        if (!reset && fetch_o.valid && ready) begin
            n_checks++;
            if (fetch_o.pc !== exp_pc) begin
                n_errors++;
                $display("Fail at %0t ns: pc %h, expected %h", $time, fetch_o.pc, exp_pc);
            end
            if (fetch_o.instr !== expected_instr(exp_pc)) begin
                n_errors++;
                $display("Fail at %0t ns: instr %h at %h, expected %h", $time,
                         fetch_o.instr, exp_pc, expected_instr(exp_pc));
            end
            if (fetch_o.tag !== exp_tag) begin
                n_errors++;
                $display("Fail at %0t ns: tag %0d, expected %0d", $time, fetch_o.tag, exp_tag);
            end
            exp_pc = exp_pc + 32'd4;          // Sequential flow
            n_items++;
        end
    end

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset   = 1'b0;
        exp_pc  = START_ADDR;
        exp_tag = '0;
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        n_checks += 2;
        if (fetch_o.valid !== 1'b0) begin
            n_errors++;
            $display("Fail at %0t ns: fetch_o.valid not low after reset", $time);
        end
        if (load_ack !== 1'b0) begin
            n_errors++;
            $display("Fail at %0t ns: load_ack_o not low after reset", $time);
        end
    endtask

    // Waits for ack, then closes the four-phase handshake
    task automatic finish_load();
        do @(negedge clk); while (!load_ack);
        ref_mem[load_addr] = load_data;       // Write is done once ack is seen
        after_edge();
        load_req = 1'b0;
        do @(negedge clk); while (load_ack);
    endtask

    task automatic load_word(word_idx_t idx, instr_t data);
        after_edge();
        load_req  = 1'b1;
        load_addr = idx;
        load_data = data;
        finish_load();
    endtask

    // Pulses a redirect for one cycle and moves the model to the new path at its edge
    task automatic redirect(logic ret, logic exc, logic irq, logic jmp,
                            addr_t target, addr_t expect_pc);
        after_edge();
        mret          = ret;
        exception     = exc;
        interrupt_ack = irq;
        jump          = jmp;
        jump_target   = target;
        @(posedge clk);
        exp_pc  = expect_pc;
        exp_tag = exp_tag + 3'd1;
        #1;
        {mret, exception, interrupt_ack, jump} = '0;
    endtask

    task automatic take_items(int n);
        int goal;
        goal = n_items + n;
        wait (n_items >= goal);
    endtask

    task automatic end_test(int num, string name);
        $display("Test %0d %s: %0d errors", num, name, n_errors - errs_at_start);
        errs_at_start = n_errors;
    endtask

    initial begin
        int goal;
        void'($urandom(96));
        {reset, run, ready} = 3'b101;
        {exception, interrupt_ack, mret, jump, load_req} = '0;
        {jump_target, mtvec, mepc} = '0;
        load_addr = '0;
        load_data = '0;
        {n_items, n_checks, n_errors, errs_at_start} = '0;
        apply_reset();
        check_reset_state();
        for (int i = 0; i < IMEM_WORDS; i++) load_word(word_idx_t'(i), $urandom());
        after_edge();
        run = 1'b1;
        take_items(20);
        end_test(1, "sequential fetch");
        for (int k = 0; k < 9; k++) begin     // Nine redirects wrap the tag
            jump_target = addr_t'($urandom_range(0, IMEM_WORDS - 1)) << 2;
            redirect(1'b0, 1'b0, 1'b0, 1'b1, jump_target, jump_target);
            take_items(3);
        end
        end_test(2, "jumps and tag wrap");
        after_edge();
        mepc  = 32'h0000_0200;
        mtvec = 32'h0000_0100;
        redirect(1'b1, 1'b1, 1'b0, 1'b1, 32'h40, 32'h200);   // Return wins
        take_items(4);
        redirect(1'b0, 1'b1, 1'b0, 1'b1, 32'h40, 32'h100);   // Trap beats jump
        take_items(4);
        redirect(1'b0, 1'b0, 1'b1, 1'b1, 32'h40, 32'h100);
        take_items(4);
        end_test(3, "redirect priority");
        redirect(1'b0, 1'b0, 1'b0, 1'b1, START_ADDR, START_ADDR);
        goal = n_items + 40;
        while (n_items < goal) begin
            after_edge();
            ready = 1'($urandom_range(0, 1));
        end
        after_edge();
        ready = 1'b1;
        end_test(4, "back-pressure");
        redirect(1'b0, 1'b0, 1'b0, 1'b1, START_ADDR, START_ADDR);
        for (int i = 0; i < 8; i++) load_word(word_idx_t'(200 + i), $urandom());
        redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'd800, 32'd800);   // Word 200
        take_items(8);
        end_test(5, "loads during fetch");
        after_edge();
        ready     = 1'b0;                     // One item waits at the output
        load_req  = 1'b1;
        load_addr = word_idx_t'(250);
        load_data = $urandom();
        do @(negedge clk); while (!(load_ack && fetch_o.valid));
        ref_mem[load_addr] = load_data;
        after_edge();
        apply_reset();                        // Load ack and output valid both high here
        check_reset_state();
        after_edge();
        ready = 1'b1;
        finish_load();                        // Loader repeats the still open write
        take_items(10);
        end_test(6, "reset");
        chk_fails = dut.u_chk.fail_count;
        $display("Checks %0d, items %0d, errors %0d, assertion failures %0d",
                 n_checks, n_items, n_errors, chk_fails);
        if (n_errors == 0 && chk_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(BUDGET_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim/fetch_chk.sv ====
//############################
// Protocol assertions for the fetch
// front end, bound into fetch_top
//############################

`timescale 1ns/1ps

module fetch_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    ready_i,
    input logic                    fetch_req_i,
    input logic                    fetch_ack_i,
    input logic                    load_bus_req_i,
    input logic                    load_bus_ack_i,
    input logic                    load_req_i,
    input logic                    load_ack_i,
    input logic                    mem_en_i,
    input imem_bus_pkg::imem_req_t mem_bus_i,
    input rv_core_pkg::fetch_out_t fetch_i
);

    int fail_count = 0;                       // Read by the testbench at the end

    // Ack may outlive req by the one cycle of the falling phase
    assert property (@(posedge clk) disable iff (reset)
        fetch_ack_i |-> (fetch_req_i || $past(fetch_req_i)))
        else begin $error("fetch ack without req"); fail_count++; end

    assert property (@(posedge clk) disable iff (reset)
        load_bus_ack_i |-> (load_bus_req_i || $past(load_bus_req_i)))
        else begin $error("loader bus ack without req"); fail_count++; end

    assert property (@(posedge clk) disable iff (reset)
        load_ack_i |-> (load_req_i || $past(load_req_i)))
        else begin $error("load port ack without req"); fail_count++; end

    assert property (@(posedge clk) disable iff (reset)
        (fetch_i.valid && !ready_i) |=> $stable(fetch_i))
        else begin $error("fetch output changed under back-pressure"); fail_count++; end

    // Each memory access belongs to the one client with an open req
    assert property (@(posedge clk) disable iff (reset)
        mem_en_i |-> (mem_bus_i.we ? load_bus_req_i : fetch_req_i))
        else begin $error("memory access without its owner's req"); fail_count++; end

endmodule

bind fetch_top fetch_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .ready_i        (ready_i),
    .fetch_req_i    (fetch_req),
    .fetch_ack_i    (fetch_ack),
    .load_bus_req_i (load_bus_req),
    .load_bus_ack_i (load_bus_ack),
    .load_req_i     (load_req_i),
    .load_ack_i     (load_ack_o),
    .mem_en_i       (mem_en),
    .mem_bus_i      (mem_bus),
    .fetch_i        (fetch_o)
);

// ==== sim/tb_clock.sv ====
//############################
// Testbench clock source
// Free running, 4 ns period
//############################

`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;            // Half period
    end

endmodule

// ==== logic/fetch_top.sv ====
//############################
// Fetch front end top
// Redirect control, fetch unit, loader,
// arbiter and instruction memory
//############################

`timescale 1ns/1ps

module fetch_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run_i,
    input  logic                    ready_i,
    input  logic                    exception_i,
    input  logic                    interrupt_ack_i,
    input  logic                    mret_i,
    input  logic                    jump_i,
    input  rv_core_pkg::addr_t      jump_target_i,
    input  rv_core_pkg::addr_t      mtvec_i,
    input  rv_core_pkg::addr_t      mepc_i,
    input  logic                    load_req_i,
    input  imem_bus_pkg::word_idx_t load_addr_i,
    input  rv_core_pkg::instr_t     load_data_i,
    output logic                    load_ack_o,
    output rv_core_pkg::fetch_out_t fetch_o
);

    import rv_core_pkg::*;
    import imem_bus_pkg::*;

    redirect_t redirect;                      // Resolved redirect to fetch

    logic      fetch_req, fetch_ack;          // Fetch client handshake
    imem_req_t fetch_bus;
    instr_t    fetch_rdata;

    logic      load_bus_req, load_bus_ack;    // Loader client handshake
    imem_req_t load_bus;

    logic      mem_en;
    imem_req_t mem_bus;
    instr_t    mem_rdata;

    redirect_ctrl u_redirect (
        .exception_i     (exception_i),
        .interrupt_ack_i (interrupt_ack_i),
        .mret_i          (mret_i),
        .jump_i          (jump_i),
        .jump_target_i   (jump_target_i),
        .mtvec_i         (mtvec_i),
        .mepc_i          (mepc_i),
        .redirect_o      (redirect)
    );

    fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .run_i      (run_i),
        .ready_i    (ready_i),
        .redirect_i (redirect),
        .req_o      (fetch_req),
        .req_o_data (fetch_bus),
        .ack_i      (fetch_ack),
        .rdata_i    (fetch_rdata),
        .fetch_o    (fetch_o)
    );

    prog_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .load_req_i  (load_req_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .load_ack_o  (load_ack_o),
        .bus_req_o   (load_bus_req),
        .bus_o       (load_bus),
        .bus_ack_i   (load_bus_ack)
    );

    imem_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .load_req_i    (load_bus_req),
        .load_bus_i    (load_bus),
        .load_ack_o    (load_bus_ack),
        .fetch_req_i   (fetch_req),
        .fetch_bus_i   (fetch_bus),
        .fetch_ack_o   (fetch_ack),
        .fetch_rdata_o (fetch_rdata),
        .mem_en_o      (mem_en),
        .mem_bus_o     (mem_bus),
        .mem_rdata_i   (mem_rdata)
    );

    imem u_imem (
        .clk     (clk),
        .en_i    (mem_en),
        .bus_i   (mem_bus),
        .rdata_o (mem_rdata)
    );

endmodule

// ==== logic/prog_loader.sv ====
//############################
// Program loader
// Takes one external word write and
// replays it as a memory write client
//############################

`timescale 1ns/1ps

module prog_loader (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_req_i,
    input  imem_bus_pkg::word_idx_t load_addr_i,
    input  rv_core_pkg::instr_t     load_data_i,
    output logic                    load_ack_o,
    output logic                    bus_req_o,
    output imem_bus_pkg::imem_req_t bus_o,
    input  logic                    bus_ack_i
);

    import rv_core_pkg::*;
    import imem_bus_pkg::*;

    typedef enum logic [1:0] {
        LD_IDLE,                              // Waiting for an external write
        LD_BUS,                               // Internal req high
        LD_BUS_LOW,                           // Internal req low, ack still high
        LD_ACK                                // External ack high
    } load_state_e;

    load_state_e state_q;
    word_idx_t   addr_q;                      // Latched word index
    instr_t      data_q;                      // Latched word

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= LD_IDLE;
        end else begin
            case (state_q)
                LD_IDLE:    if (load_req_i) state_q <= LD_BUS;
                LD_BUS:     if (bus_ack_i) state_q <= LD_BUS_LOW;
                LD_BUS_LOW: if (!bus_ack_i) state_q <= LD_ACK;   // Write fully closed
                LD_ACK:     if (!load_req_i) state_q <= LD_IDLE;
                default:    state_q <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LD_IDLE && load_req_i) begin
            addr_q <= load_addr_i;
            data_q <= load_data_i;
        end
    end

    assign bus_req_o  = (state_q == LD_BUS);
    assign load_ack_o = (state_q == LD_ACK);

    always_comb begin
        bus_o.we    = 1'b1;                   // Loader only writes
        bus_o.idx   = addr_q;
        bus_o.wdata = data_q;
    end

endmodule

// ==== logic/imem.sv ====
//############################
// Instruction memory
// Single port, synchronous, one cycle read
//############################

`timescale 1ns/1ps

module imem (
    input  logic                    clk,
    input  logic                    en_i,
    input  imem_bus_pkg::imem_req_t bus_i,
    output rv_core_pkg::instr_t     rdata_o
);

    import rv_core_pkg::*;
    import imem_bus_pkg::*;

    instr_t mem [IMEM_WORDS];                 // Program storage

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (bus_i.we) begin
                mem[bus_i.idx] <= bus_i.wdata;
            end
            rdata_o <= mem[bus_i.idx];        // Old word on a write cycle
        end
    end

endmodule

// ==== logic/imem_arbiter.sv ====
//############################
// Instruction memory arbiter
// Fixed priority, loader first, with
// four-phase req/ack toward each client
//############################

`timescale 1ns/1ps

module imem_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load_req_i,
    input  imem_bus_pkg::imem_req_t load_bus_i,
    output logic                    load_ack_o,
    input  logic                    fetch_req_i,
    input  imem_bus_pkg::imem_req_t fetch_bus_i,
    output logic                    fetch_ack_o,
    output rv_core_pkg::instr_t     fetch_rdata_o,
    output logic                    mem_en_o,
    output imem_bus_pkg::imem_req_t mem_bus_o,
    input  rv_core_pkg::instr_t     mem_rdata_i
);

    import imem_bus_pkg::*;

    client_e owner_q;                         // Who holds the memory
    logic    served_q;                        // Access done, ack phase running
    logic    owner_req;                       // req of the current owner

    assign owner_req = (owner_q == CLIENT_LOAD) ? load_req_i : fetch_req_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner_q  <= CLIENT_NONE;
            served_q <= 1'b0;
        end else begin
            case (owner_q)
                CLIENT_NONE: begin
                    if (load_req_i) begin
                        owner_q <= CLIENT_LOAD;    // Loader beats fetch
                    end else if (fetch_req_i) begin
                        owner_q <= CLIENT_FETCH;
                    end
                end
                default: begin
                    if (!served_q) begin
                        served_q <= 1'b1;          // Memory access happens this cycle
                    end else if (!owner_req) begin
                        owner_q  <= CLIENT_NONE;   // Owner let go, drop ack
                        served_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    // Memory is touched only in the single access cycle
    assign mem_en_o  = (owner_q != CLIENT_NONE) && !served_q;
    assign mem_bus_o = (owner_q == CLIENT_LOAD) ? load_bus_i : fetch_bus_i;

    assign load_ack_o  = served_q && (owner_q == CLIENT_LOAD);
    assign fetch_ack_o = served_q && (owner_q == CLIENT_FETCH);

    // Read data holds while ack is high since nothing else enables the memory
    assign fetch_rdata_o = mem_rdata_i;

endmodule

// ==== fetch/fetch.sv ====
//############################
// Fetch unit
// Holds pc and redirect tag, reads the
// instruction memory over four-phase req/ack
// and presents each word with pc and tag
//############################

`timescale 1ns/1ps

module fetch (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     run_i,
    input  logic                     ready_i,
    input  rv_core_pkg::redirect_t   redirect_i,
    output logic                     req_o,
    output imem_bus_pkg::imem_req_t  req_o_data,
    input  logic                     ack_i,
    input  rv_core_pkg::instr_t      rdata_i,
    output rv_core_pkg::fetch_out_t  fetch_o
);

    import rv_core_pkg::*;
    import imem_bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,                                 // Not fetching
        REQ,                                  // req high, waiting for ack
        WAIT_LOW,                             // req dropped, waiting for ack to fall
        HOLD                                  // Output blocked by back-pressure
    } fetch_state_e;

    fetch_state_e state_q, state_d;

    addr_t  pc_q;                             // Next address to fetch
    addr_t  req_addr_q;                       // Address of the request in flight
    tag_t   tag_q;                            // Current path tag
    logic   stale_q;                          // In-flight fetch hit by a redirect

    logic   out_valid_q;
    addr_t  out_pc_q;
    instr_t out_instr_q;
    tag_t   out_tag_q;

    logic   out_blocked;                      // Item held, consumer not ready
    logic   issue;                            // A new request starts this edge
    logic   capture;                          // Returned word is kept

    assign out_blocked = out_valid_q & ~ready_i;
    assign issue       = (state_d == REQ) && (state_q != REQ);
    assign capture     = (state_q == REQ) && ack_i && !(stale_q || redirect_i.valid);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:     if (run_i && !out_blocked) state_d = REQ;
            REQ:      if (ack_i) state_d = WAIT_LOW;
            WAIT_LOW: begin
                if (!ack_i) begin
                    if (out_blocked)  state_d = HOLD;
                    else if (run_i)   state_d = REQ;   // Back-to-back request
                    else              state_d = IDLE;
                end
            end
            HOLD:     if (!out_blocked) state_d = run_i ? REQ : IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            pc_q    <= START_ADDR;
            tag_q   <= '0;
            stale_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (redirect_i.valid) begin
                pc_q  <= redirect_i.target;   // Redirect wins over sequential flow
                tag_q <= tag_q + 3'd1;        // One step per redirect, wraps
            end else if (issue) begin
                pc_q  <= pc_q + 32'd4;
            end
            if (issue) begin
                stale_q <= redirect_i.valid;  // Issued on the old path
            end else if (state_q == REQ && redirect_i.valid) begin
                stale_q <= 1'b1;
            end
        end
    end

    // Request address stays put while req is high
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= 1'b0;
        end else if (capture) begin
            out_valid_q <= 1'b1;
        end else if (ready_i) begin
            out_valid_q <= 1'b0;              // Item taken
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_pc_q    <= req_addr_q;
            out_instr_q <= rdata_i;
            out_tag_q   <= tag_q;
        end
    end

    assign req_o = (state_q == REQ);

    always_comb begin
        req_o_data.we    = 1'b0;              // Fetch only reads
        req_o_data.idx   = word_idx_t'(req_addr_q >> 2);
        req_o_data.wdata = '0;
    end

    always_comb begin
        fetch_o.valid = out_valid_q;
        fetch_o.pc    = out_pc_q;
        fetch_o.instr = out_instr_q;
        fetch_o.tag   = out_tag_q;
    end

endmodule

// ==== fetch/redirect_ctrl.sv ====
//############################
// Redirect controller
// Merges return, trap and jump requests
// into a single prioritized redirect
//############################

`timescale 1ns/1ps

module redirect_ctrl (
    input  logic                   exception_i,
    input  logic                   interrupt_ack_i,
    input  logic                   mret_i,
    input  logic                   jump_i,
    input  rv_core_pkg::addr_t     jump_target_i,
    input  rv_core_pkg::addr_t     mtvec_i,
    input  rv_core_pkg::addr_t     mepc_i,
    output rv_core_pkg::redirect_t redirect_o
);

    import rv_core_pkg::*;

    addr_t target;                            // Winning target address
    logic  trap;                              // Exception or interrupt taken

    assign trap = exception_i | interrupt_ack_i;

    // Machine return beats trap, trap beats jump
    always_comb begin
        target = jump_target_i;
        if (mret_i) begin
            target = mepc_i;                  // Back to the interrupted code
        end else if (trap) begin
            target = mtvec_i;                 // Enter the handler
        end
    end

    always_comb begin
        redirect_o.valid  = mret_i | trap | jump_i;
        redirect_o.target = target;
    end

endmodule

// ==== common/imem_bus_pkg.sv ====
//############################
// Instruction memory bus
// Request bundle, client ids and sizing
// shared by the arbiter and its clients
//############################

package imem_bus_pkg;

    localparam int IMEM_WORDS = 256;          // Memory depth in words

    typedef logic [$clog2(IMEM_WORDS)-1:0] word_idx_t;   // Word index into the array

    // Request held stable by a client while its req is high
    typedef struct packed {
        logic                  we;            // Write when set, read otherwise
        word_idx_t             idx;           // Target word
        rv_core_pkg::instr_t   wdata;         // Ignored on reads
    } imem_req_t;                             // 41 bits

    // Current owner of the memory
    typedef enum logic [1:0] {
        CLIENT_NONE  = 2'd0,                  // Arbiter idle
        CLIENT_LOAD  = 2'd1,                  // Program loader, highest priority
        CLIENT_FETCH = 2'd2                   // Fetch unit
    } client_e;

endpackage

// ==== common/rv_core_pkg.sv ====
//############################
// Core types for the fetch front end
// Address, instruction and redirect tag widths,
// redirect and fetch output bundles
//############################

package rv_core_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] addr_t;              // Byte address
    typedef logic [31:0] instr_t;             // Raw instruction word
    typedef logic [2:0]  tag_t;               // Redirect tag, wraps after 7

    localparam addr_t START_ADDR = 32'h0000_0000;   // pc value after reset

    // One redirect request after priority resolution
    typedef struct packed {
        logic  valid;                         // Some source wants a new pc
        addr_t target;                        // Where fetch continues
    } redirect_t;                             // 33 bits

    // One fetched instruction leaving the front end
    typedef struct packed {
        logic   valid;                        // Qualified by ready on the consumer side
        addr_t  pc;                           // Address the word came from
        instr_t instr;                        // The word itself
        tag_t   tag;                          // Path tag at fetch time
    } fetch_out_t;                            // 68 bits

endpackage
